// ==== sim.f ====
mem_pkg.sv
sram_1rw.sv
store_align.sv
load_extend.sv
mem_port_mux.sv
mem_subsystem.sv
tb_mem_subsystem.sv

// ==== run.sh ====
#!/bin/sh
# Build the memory subsystem testbench with Verilator, run it, check the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_mem_subsystem \
    -f sim.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qs "TB PASSED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== tb_mem_subsystem.sv ====
// ------------------------------
// Testbench for the memory subsystem. Random loader and core traffic
// is checked against a byte model of both memories, one cycle behind
// ------------------------------
module tb_mem_subsystem;

    timeunit 1ns;
    timeprecision 100ps;

    // ------------------------------
    // Run length and stimulus setup
    // ------------------------------
    localparam int          N_PHASES      = 4;
    localparam int          OPS_PER_PHASE = 500;
    localparam int          MAX_CYCLES    = 2 * N_PHASES * OPS_PER_PHASE;  // Twice the run
    localparam int          WIN_WORDS     = 64;  // Words per memory used by the test
    localparam logic [31:0] SEED          = 32'heb34;
    localparam int          MEM_BYTES     = mem_pkg::MEM_DEPTH * mem_pkg::BYTES_PER_WORD;

    logic                              clk;
    logic                              rst_i;
    mem_pkg::loader_req_t              loader_req_i;
    logic [mem_pkg::BYTE_ADDR_W-1:0]   core_pc_i;
    mem_pkg::core_data_req_t           core_data_req_i;
    logic [mem_pkg::DATA_W-1:0]        core_instr_o;
    logic [mem_pkg::DATA_W-1:0]        core_rdata_o;
    logic [mem_pkg::DATA_W-1:0]        loader_rdata_o;
    logic                              loader_rvalid_o;

    logic [7:0] inst_bytes [MEM_BYTES];  // Instruction memory model
    logic [7:0] data_bytes [MEM_BYTES];  // Data memory model

    // Expected results of last cycle's requests
    logic                       exp_rvalid;
    logic [mem_pkg::DATA_W-1:0] exp_ldata;
    logic                       chk_instr;
    logic [mem_pkg::DATA_W-1:0] exp_instr;
    logic                       chk_load;
    logic [mem_pkg::DATA_W-1:0] exp_load;
    logic                       inst_filled;  // Window of each memory written once
    logic                       data_filled;
    int                         errors;
    int                         cycles;

    mem_subsystem DUT (
        .clk             (clk),
        .rst_i           (rst_i),
        .loader_req_i    (loader_req_i),
        .core_pc_i       (core_pc_i),
        .core_data_req_i (core_data_req_i),
        .core_instr_o    (core_instr_o),
        .core_rdata_o    (core_rdata_o),
        .loader_rdata_o  (loader_rdata_o),
        .loader_rvalid_o (loader_rvalid_o)
    );

    always #50 clk = ~clk;  // 100 ns period

    // Cycle limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the test did not reach its end", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    // ------------------------------
    // Memory model
    // ------------------------------
    function automatic logic [mem_pkg::DATA_W-1:0] model_word(
        mem_pkg::mem_sel_e sel, logic [mem_pkg::WORD_ADDR_W-1:0] idx);
        logic [mem_pkg::DATA_W-1:0] w;
        for (int b = 0; b < 4; b++) begin
            if (sel == mem_pkg::SEL_DATA) begin
                w[8*b +: 8] = data_bytes[{idx, 2'(b)}];
            end else begin
                w[8*b +: 8] = inst_bytes[{idx, 2'(b)}];
            end
        end
        return w;
    endfunction

    task automatic write_model_word(mem_pkg::mem_sel_e sel,
                                    logic [mem_pkg::WORD_ADDR_W-1:0] idx,
                                    logic [mem_pkg::DATA_W-1:0] w);
        for (int b = 0; b < 4; b++) begin
            if (sel == mem_pkg::SEL_DATA) begin
                data_bytes[{idx, 2'(b)}] = w[8*b +: 8];
            end else begin
                inst_bytes[{idx, 2'(b)}] = w[8*b +: 8];
            end
        end
    endtask

    // Store writes the low 1, 2 or 4 bytes of wdata from the byte address up
    task automatic apply_core_store(mem_pkg::core_data_req_t req);
        int n;
        case (req.width)
            mem_pkg::WIDTH_B: n = 1;
            mem_pkg::WIDTH_H: n = 2;
            default:          n = 4;
        endcase
        for (int b = 0; b < n; b++) begin
            data_bytes[req.addr + 11'(b)] = req.wdata[8*b +: 8];
        end
    endtask

    function automatic logic [mem_pkg::DATA_W-1:0] expected_load(
        mem_pkg::mem_width_e width, logic [mem_pkg::BYTE_ADDR_W-1:0] addr);
        logic [7:0]  b0;
        logic [15:0] h0;
        b0 = data_bytes[addr];
        h0 = {data_bytes[addr + 11'd1], data_bytes[addr]};  // Little endian
        case (width)
            mem_pkg::WIDTH_B:  return {{24{b0[7]}}, b0};
            mem_pkg::WIDTH_BU: return {24'd0, b0};
            mem_pkg::WIDTH_H:  return {{16{h0[15]}}, h0};
            mem_pkg::WIDTH_HU: return {16'd0, h0};
            default:           return {data_bytes[addr + 11'd3], data_bytes[addr + 11'd2], h0};
        endcase
    endfunction

    // ------------------------------
    // Random stimulus
    // ------------------------------
    // Window index spread over all nine word address bits
    function automatic logic [mem_pkg::WORD_ADDR_W-1:0] win_word(int i);
        logic [5:0] k;
        k = 6'(i);
        return {k, k[2:0]};
    endfunction

    function automatic logic [mem_pkg::WORD_ADDR_W-1:0] rand_word();
        return win_word($urandom_range(0, WIN_WORDS - 1));
    endfunction

    function automatic logic [mem_pkg::BYTE_ADDR_W-1:0] rand_pc();
        return {rand_word(), 2'b00};  // Word aligned fetch
    endfunction

    function automatic mem_pkg::mem_sel_e rand_sel();
        return ($urandom_range(0, 1) == 0) ? mem_pkg::SEL_INST : mem_pkg::SEL_DATA;
    endfunction

    function automatic mem_pkg::loader_req_t loader_op(logic we, mem_pkg::mem_sel_e sel,
        logic [mem_pkg::WORD_ADDR_W-1:0] idx, logic [mem_pkg::DATA_W-1:0] wdata);
        mem_pkg::loader_req_t r;
        r.stb   = 1'b1;
        r.we    = we;
        r.sel   = sel;
        r.addr  = idx;
        r.wdata = wdata;
        return r;
    endfunction

    function automatic mem_pkg::loader_req_t no_loader();
        return '0;
    endfunction

    function automatic mem_pkg::core_data_req_t rand_core_req(logic store);
        mem_pkg::core_data_req_t r;
        logic [1:0]              off;
        r.we    = store;
        r.wdata = $urandom();
        if (store) begin
            case ($urandom_range(0, 2))
                0:       r.width = mem_pkg::WIDTH_B;
                1:       r.width = mem_pkg::WIDTH_H;
                default: r.width = mem_pkg::WIDTH_W;
            endcase
        end else begin
            case ($urandom_range(0, 4))
                0:       r.width = mem_pkg::WIDTH_B;
                1:       r.width = mem_pkg::WIDTH_BU;
                2:       r.width = mem_pkg::WIDTH_H;
                3:       r.width = mem_pkg::WIDTH_HU;
                default: r.width = mem_pkg::WIDTH_W;
            endcase
        end
        // Offset aligned to the access width
        case (r.width)
            mem_pkg::WIDTH_B, mem_pkg::WIDTH_BU: off = 2'($urandom_range(0, 3));
            mem_pkg::WIDTH_H, mem_pkg::WIDTH_HU: off = {1'($urandom_range(0, 1)), 1'b0};
            default:                             off = 2'b00;
        endcase
        r.addr = {rand_word(), off};
        return r;
    endfunction

    // ------------------------------
    // Checks and cycle driver
    // ------------------------------
    task automatic check_outputs();
        assert (loader_rvalid_o === exp_rvalid) else begin
            errors++;
            $display("[ERROR] %0d ns: loader_rvalid_o is %0b, expected %0b",
                     $time, loader_rvalid_o, exp_rvalid);
        end
        if (exp_rvalid) begin
            assert (loader_rdata_o === exp_ldata) else begin
                errors++;
                $display("[ERROR] %0d ns: loader_rdata_o is %h, expected %h",
                         $time, loader_rdata_o, exp_ldata);
            end
        end
        if (chk_instr) begin
            assert (core_instr_o === exp_instr) else begin
                errors++;
                $display("[ERROR] %0d ns: core_instr_o is %h, expected %h",
                         $time, core_instr_o, exp_instr);
            end
        end
        if (chk_load) begin
            assert (core_rdata_o === exp_load) else begin
                errors++;
                $display("[ERROR] %0d ns: core_rdata_o is %h, expected %h",
                         $time, core_rdata_o, exp_load);
            end
        end
    endtask

    // Checks last cycle's results, then drives one new set of requests
    task automatic run_cycle(mem_pkg::loader_req_t lreq,
                             logic [mem_pkg::BYTE_ADDR_W-1:0] pc,
                             mem_pkg::core_data_req_t creq);
        logic loader_inst;
        logic loader_data;
        @(posedge clk);
        #10;
        check_outputs();
        loader_inst = lreq.stb && (lreq.sel == mem_pkg::SEL_INST);
        loader_data = lreq.stb && (lreq.sel == mem_pkg::SEL_DATA);
        // Reads see the model before this cycle's writes
        exp_rvalid = lreq.stb && !lreq.we;
        exp_ldata  = model_word(lreq.sel, lreq.addr);
        chk_instr  = inst_filled && !loader_inst;  // Fetch lost under a loader strobe
        exp_instr  = model_word(mem_pkg::SEL_INST,
                                pc[mem_pkg::BYTE_ADDR_W-1:mem_pkg::OFFSET_W]);
        chk_load   = data_filled && !loader_data && !creq.we;
        exp_load   = expected_load(creq.width, creq.addr);
        if (lreq.stb && lreq.we) begin
            write_model_word(lreq.sel, lreq.addr, lreq.wdata);
        end
        if (creq.we && !loader_data) begin
            apply_core_store(creq);  // Store dropped when loader owns the port
        end
        loader_req_i    = lreq;
        core_pc_i       = pc;
        core_data_req_i = creq;
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        mem_pkg::core_data_req_t         creq;
        mem_pkg::loader_req_t            lreq;
        logic [mem_pkg::WORD_ADDR_W-1:0] hit_word;
        logic                            hit_pending;
        int                              pick;
        void'($urandom(SEED));
        clk             = 1'b0;
        rst_i           = 1'b1;
        loader_req_i    = '0;
        core_pc_i       = '0;
        core_data_req_i = '0;
        exp_rvalid      = 1'b0;
        exp_ldata       = '0;
        chk_instr       = 1'b0;
        exp_instr       = '0;
        chk_load        = 1'b0;
        exp_load        = '0;
        inst_filled     = 1'b0;
        data_filled     = 1'b0;
        hit_pending     = 1'b0;
        hit_word        = '0;
        errors          = 0;
        cycles          = 0;
        repeat (2) @(posedge clk);
        #10;
        rst_i = 1'b0;

        // Valid must stay low while no strobe has been given
        repeat (4) run_cycle(no_loader(), rand_pc(), rand_core_req(1'b0));

        // Phase 1 fills both windows and then runs random loader reads and writes
        for (int i = 0; i < OPS_PER_PHASE; i++) begin
            if (i < WIN_WORDS) begin
                lreq = loader_op(1'b1, mem_pkg::SEL_INST, win_word(i), $urandom());
            end else if (i < 2 * WIN_WORDS) begin
                lreq = loader_op(1'b1, mem_pkg::SEL_DATA, win_word(i - WIN_WORDS), $urandom());
            end else begin
                lreq = loader_op(1'($urandom_range(0, 1)), rand_sel(), rand_word(), $urandom());
            end
            run_cycle(lreq, rand_pc(), rand_core_req(1'b0));
            if (i == WIN_WORDS - 1) begin
                inst_filled = 1'b1;
            end
            if (i == 2 * WIN_WORDS - 1) begin
                data_filled = 1'b1;
            end
        end

        // Phase 2 fetches with loader readbacks that steal the fetch slot
        for (int i = 0; i < OPS_PER_PHASE; i++) begin
            if ($urandom_range(0, 7) == 0) begin
                lreq = loader_op(1'b0, mem_pkg::SEL_INST, rand_word(), '0);
            end else begin
                lreq = no_loader();
            end
            run_cycle(lreq, rand_pc(), rand_core_req(1'b0));
        end

        // Phase 3 core stores with data readbacks and loader collisions
        for (int i = 0; i < OPS_PER_PHASE; i++) begin
            creq = rand_core_req(1'b1);
            pick = $urandom_range(0, 7);
            if (hit_pending) begin
                lreq        = loader_op(1'b0, mem_pkg::SEL_DATA, hit_word, '0);
                hit_pending = 1'b0;  // Loader word must come back
            end else if (pick == 0) begin
                hit_word    = creq.addr[mem_pkg::BYTE_ADDR_W-1:mem_pkg::OFFSET_W];
                lreq        = loader_op(1'b1, mem_pkg::SEL_DATA, hit_word, $urandom());
                hit_pending = 1'b1;
            end else if (pick < 3) begin
                lreq = loader_op(1'b0, mem_pkg::SEL_DATA, rand_word(), '0);
            end else begin
                lreq = no_loader();
            end
            run_cycle(lreq, rand_pc(), creq);
        end

        // Phase 4 loads of all widths with a few stores mixed in
        for (int i = 0; i < OPS_PER_PHASE; i++) begin
            pick = $urandom_range(0, 7);
            creq = rand_core_req(pick == 0);
            if (pick == 1) begin
                lreq = loader_op(1'b0, mem_pkg::SEL_INST, rand_word(), '0);
            end else begin
                lreq = no_loader();
            end
            run_cycle(lreq, rand_pc(), creq);
        end

        @(posedge clk);
        #10;
        check_outputs();  // Results of the last requests

        $display("Run ended after %0d cycles with %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== mem_subsystem.sv ====
// ----------------------------
// Memory side of the SoC wrapper. Instruction and data memories
// shared by the host loader and the core, 1 cycle read latency
// ----------------------------
module mem_subsystem (
    input  logic                              clk,
    input  logic                              rst_i,
    input  mem_pkg::loader_req_t              loader_req_i,     // Host load and readback
    input  logic [mem_pkg::BYTE_ADDR_W-1:0]   core_pc_i,        // Fetch address
    input  mem_pkg::core_data_req_t           core_data_req_i,  // Core load or store
    output logic [mem_pkg::DATA_W-1:0]        core_instr_o,     // Fetched instruction
    output logic [mem_pkg::DATA_W-1:0]        core_rdata_o,     // Extended load data
    output logic [mem_pkg::DATA_W-1:0]        loader_rdata_o,   // Readback word
    output logic                              loader_rvalid_o   // Readback valid
);

    // ----------------------------
    // Internal nets
    // ----------------------------
    logic [mem_pkg::WORD_ADDR_W-1:0]    core_word_addr;  // Aligned data word index
    logic [mem_pkg::BYTES_PER_WORD-1:0] core_mask;       // Store lane mask
    logic [mem_pkg::DATA_W-1:0]         core_wdata;      // Store data in lanes
    mem_pkg::sram_req_t                 inst_req;        // Instruction memory port
    mem_pkg::sram_req_t                 data_req;        // Data memory port
    logic [mem_pkg::DATA_W-1:0]         inst_rdata;
    logic [mem_pkg::DATA_W-1:0]         data_rdata;

    // Core store alignment
    store_align u_store_align (
        .req_i       (core_data_req_i),
        .word_addr_o (core_word_addr),
        .mask_o      (core_mask),
        .wdata_o     (core_wdata)
    );

    // Loader versus core steering
    mem_port_mux u_port_mux (
        .clk              (clk),
        .rst_i            (rst_i),
        .loader_req_i     (loader_req_i),
        .core_pc_i        (core_pc_i),
        .core_word_addr_i (core_word_addr),
        .core_mask_i      (core_mask),
        .core_wdata_i     (core_wdata),
        .core_we_i        (core_data_req_i.we),
        .inst_rdata_i     (inst_rdata),
        .data_rdata_i     (data_rdata),
        .inst_req_o       (inst_req),
        .data_req_o       (data_req),
        .loader_rdata_o   (loader_rdata_o),
        .loader_rvalid_o  (loader_rvalid_o)
    );

    // ----------------------------
    // Memories
    // ----------------------------
    sram_1rw u_inst_mem (
        .clk     (clk),
        .req_i   (inst_req),
        .rdata_o (inst_rdata)
    );

    sram_1rw u_data_mem (
        .clk     (clk),
        .req_i   (data_req),
        .rdata_o (data_rdata)
    );

    assign core_instr_o = inst_rdata;  // Fetch word goes straight out

    // Load lane select and sign or zero extension
    load_extend u_load_extend (
        .clk      (clk),
        .rst_i    (rst_i),
        .width_i  (core_data_req_i.width),
        .offset_i (core_data_req_i.addr[mem_pkg::OFFSET_W-1:0]),
        .rdata_i  (data_rdata),
        .data_o   (core_rdata_o)
    );

endmodule

// ==== mem_port_mux.sv ====
// ----------------------------
// Port steering between the loader and the core for both memories.
// The loader wins on the memory it strobes
// ----------------------------
module mem_port_mux (
    input  logic                                 clk,
    input  logic                                 rst_i,
    input  mem_pkg::loader_req_t                 loader_req_i,      // Host side request
    input  logic [mem_pkg::BYTE_ADDR_W-1:0]      core_pc_i,         // Fetch byte address
    input  logic [mem_pkg::WORD_ADDR_W-1:0]      core_word_addr_i,  // Aligned data index
    input  logic [mem_pkg::BYTES_PER_WORD-1:0]   core_mask_i,       // Aligned store lanes
    input  logic [mem_pkg::DATA_W-1:0]           core_wdata_i,      // Aligned store data
    input  logic                                 core_we_i,         // Core store enable
    input  logic [mem_pkg::DATA_W-1:0]           inst_rdata_i,      // Instruction memory word
    input  logic [mem_pkg::DATA_W-1:0]           data_rdata_i,      // Data memory word
    output mem_pkg::sram_req_t                   inst_req_o,
    output mem_pkg::sram_req_t                   data_req_o,
    output logic [mem_pkg::DATA_W-1:0]           loader_rdata_o,    // Readback word
    output logic                                 loader_rvalid_o    // Readback valid pulse
);

    logic              loader_inst;  // Loader owns the instruction memory
    logic              loader_data;  // Loader owns the data memory
    logic              rvalid_q;     // Read was taken last cycle
    mem_pkg::mem_sel_e rsel_q;       // Memory of that read

    assign loader_inst = loader_req_i.stb && (loader_req_i.sel == mem_pkg::SEL_INST);
    assign loader_data = loader_req_i.stb && (loader_req_i.sel == mem_pkg::SEL_DATA);

    // ----------------------------
    // Instruction memory port
    // ----------------------------
    always_comb begin
        if (loader_inst) begin
            inst_req_o.we    = loader_req_i.we;
            inst_req_o.mask  = '1;  // Loader always writes full words
            inst_req_o.addr  = loader_req_i.addr;
            inst_req_o.wdata = loader_req_i.wdata;
        end else begin
            // Fetch path, core never writes here
            inst_req_o.we    = 1'b0;
            inst_req_o.mask  = '0;
            inst_req_o.addr  = core_pc_i[mem_pkg::BYTE_ADDR_W-1:mem_pkg::OFFSET_W];
            inst_req_o.wdata = '0;
        end
    end

    // ----------------------------
    // Data memory port
    // ----------------------------
    // Core access is dropped while the loader holds the port
    always_comb begin
        if (loader_data) begin
            data_req_o.we    = loader_req_i.we;
            data_req_o.mask  = '1;
            data_req_o.addr  = loader_req_i.addr;
            data_req_o.wdata = loader_req_i.wdata;
        end else begin
            data_req_o.we    = core_we_i;
            data_req_o.mask  = core_mask_i;       // From the store aligner
            data_req_o.addr  = core_word_addr_i;
            data_req_o.wdata = core_wdata_i;
        end
    end

    // ----------------------------
    // Loader readback
    // ----------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rvalid_q <= 1'b0;
            rsel_q   <= mem_pkg::SEL_INST;
        end else begin
            rvalid_q <= loader_req_i.stb && !loader_req_i.we;  // One pulse per read
            if (loader_req_i.stb) begin
                rsel_q <= loader_req_i.sel;  // Hold until the next strobe
            end
        end
    end

    assign loader_rvalid_o = rvalid_q;
    assign loader_rdata_o  = (rsel_q == mem_pkg::SEL_DATA) ? data_rdata_i : inst_rdata_i;

endmodule

// ==== load_extend.sv ====
// ----------------------------
// Load extender for the data memory read word. Keeps the width and
// offset for one cycle and returns the extended lane
// ----------------------------
module load_extend (
    input  logic                              clk,
    input  logic                              rst_i,
    input  mem_pkg::mem_width_e               width_i,   // Width of this cycle's access
    input  logic [mem_pkg::OFFSET_W-1:0]      offset_i,  // Byte offset of this access
    input  logic [mem_pkg::DATA_W-1:0]        rdata_i,   // Word from the data memory
    output logic [mem_pkg::DATA_W-1:0]        data_o     // Extended load result
);

    mem_pkg::mem_width_e            width_q;   // Width aligned with rdata_i
    logic [mem_pkg::OFFSET_W-1:0]   offset_q;  // Offset aligned with rdata_i
    logic [mem_pkg::DATA_W-1:0]     shifted;   // Lane moved down to bit 0

    // ----------------------------
    // Access info pipeline
    // ----------------------------
    // Matches the one-cycle latency of the memory
    always_ff @(posedge clk) begin
        if (rst_i) begin
            width_q  <= mem_pkg::WIDTH_W;  // Plain word pass-through
            offset_q <= '0;
        end else begin
            width_q  <= width_i;
            offset_q <= offset_i;
        end
    end

    // ----------------------------
    // Lane select and extend
    // ----------------------------
    assign shifted = rdata_i >> {offset_q, 3'b000};  // Drop lower lanes

    always_comb begin
        case (width_q)
            mem_pkg::WIDTH_B:  // lb
                data_o = {{(mem_pkg::DATA_W-8){shifted[7]}}, shifted[7:0]};
            mem_pkg::WIDTH_H:  // lh
                data_o = {{(mem_pkg::DATA_W-16){shifted[15]}}, shifted[15:0]};
            mem_pkg::WIDTH_BU: // lbu
                data_o = {{(mem_pkg::DATA_W-8){1'b0}}, shifted[7:0]};
            mem_pkg::WIDTH_HU: // lhu
                data_o = {{(mem_pkg::DATA_W-16){1'b0}}, shifted[15:0]};
            default:
                data_o = shifted;  // lw and unknown codes
        endcase
    end

endmodule

// ==== store_align.sv ====
// ----------------------------
// Store aligner for core data accesses. Splits the byte address and
// builds the lane mask and shifted write data for the data memory
// ----------------------------
module store_align (
    input  mem_pkg::core_data_req_t              req_i,        // Core data access
    output logic [mem_pkg::WORD_ADDR_W-1:0]      word_addr_o,  // Word index
    output logic [mem_pkg::BYTES_PER_WORD-1:0]   mask_o,       // Byte lanes to write
    output logic [mem_pkg::DATA_W-1:0]           wdata_o       // Data moved into lanes
);

    logic [mem_pkg::OFFSET_W-1:0]       offset;     // Byte position inside the word
    logic [mem_pkg::BYTES_PER_WORD-1:0] lane_mask;  // Mask before the offset shift

    // ----------------------------
    // Address split
    // ----------------------------
    assign word_addr_o = req_i.addr[mem_pkg::BYTE_ADDR_W-1:mem_pkg::OFFSET_W];
    assign offset      = req_i.addr[mem_pkg::OFFSET_W-1:0];

    // ----------------------------
    // Byte mask
    // ----------------------------
    always_comb begin
        case (req_i.width)
            mem_pkg::WIDTH_B: lane_mask = 4'b0001;  // sb
            mem_pkg::WIDTH_H: lane_mask = 4'b0011;  // sh
            default:          lane_mask = 4'b1111;  // sw and unknown codes
        endcase
    end

    // Word and unknown codes keep all four lanes unshifted
    always_comb begin
        if (req_i.width == mem_pkg::WIDTH_B || req_i.width == mem_pkg::WIDTH_H) begin
            mask_o = lane_mask << offset;  // Move to the addressed lanes
        end else begin
            mask_o = lane_mask;
        end
    end

    // ----------------------------
    // Data lane shift
    // ----------------------------
    // Low byte or halfword moves up to the target lane
    assign wdata_o = req_i.wdata << {offset, 3'b000};

endmodule

// ==== sram_1rw.sv ====
// ----------------------------
// Single-port synchronous word memory with byte write mask.
// Read word appears one cycle after the request
// ----------------------------
module sram_1rw (
    input  logic                         clk,
    input  mem_pkg::sram_req_t           req_i,    // One request per cycle
    output logic [mem_pkg::DATA_W-1:0]   rdata_o   // Registered read word
);

    // Storage array of MEM_DEPTH words
    logic [mem_pkg::DATA_W-1:0] mem_q [mem_pkg::MEM_DEPTH];

    // ----------------------------
    // Write port
    // ----------------------------
    // Each lane is written only when its mask bit is set
    always_ff @(posedge clk) begin
        for (int b = 0; b < mem_pkg::BYTES_PER_WORD; b++) begin
            if (req_i.we && req_i.mask[b]) begin
                mem_q[req_i.addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
            end
        end
    end

    // ----------------------------
    // Read port
    // ----------------------------
    // Reads every cycle and returns old contents on a same-cycle write
    always_ff @(posedge clk) begin
        rdata_o <= mem_q[req_i.addr];  // Read-first behaviour
    end

endmodule

// ==== mem_pkg.sv ====
// ----------------------------
// Shared sizes, width codes and request structs for the memory
// subsystem. Referenced by scoped name from every RTL file
// ----------------------------
package mem_pkg;

    // ----------------------------
    // Sizes and widths
    // ----------------------------
    localparam int DATA_W         = 32;                    // Word width in bits
    localparam int BYTES_PER_WORD = DATA_W / 8;            // 4 byte lanes per word
    localparam int MEM_SIZE_KB    = 2;                     // Each memory is 2 KB

    // Words per memory
    localparam int MEM_DEPTH      = (MEM_SIZE_KB * 1024) / BYTES_PER_WORD;

    localparam int WORD_ADDR_W    = $clog2(MEM_DEPTH);     // Word index width
    localparam int OFFSET_W       = $clog2(BYTES_PER_WORD); // Byte offset inside a word
    localparam int BYTE_ADDR_W    = WORD_ADDR_W + OFFSET_W; // Full byte address width

    // ----------------------------
    // Enums
    // ----------------------------
    // Core access width, encoded as RISC-V funct3 of loads and stores
    typedef enum logic [2:0] {
        WIDTH_B  = 3'd0,    // lb / sb
        WIDTH_H  = 3'd1,    // lh / sh
        WIDTH_W  = 3'd2,    // lw / sw
        WIDTH_BU = 3'd4,    // lbu
        WIDTH_HU = 3'd5     // lhu
    } mem_width_e;

    // Loader target memory
    typedef enum logic {
        SEL_INST = 1'b0,    // Instruction memory
        SEL_DATA = 1'b1     // Data memory
    } mem_sel_e;

    // ----------------------------
    // Request structs
    // ----------------------------
    // Host side loader request, one word per strobe
    typedef struct packed {
        logic                   stb;    // Request strobe
        logic                   we;     // Write when high else read
        mem_sel_e               sel;    // Which memory
        logic [WORD_ADDR_W-1:0] addr;   // Word index
        logic [DATA_W-1:0]      wdata;  // Write word
    } loader_req_t;

    // Core data access, issued every cycle
    typedef struct packed {
        logic                   we;     // Store enable
        mem_width_e             width;  // Access width code
        logic [BYTE_ADDR_W-1:0] addr;   // Byte address
        logic [DATA_W-1:0]      wdata;  // Store data in low lanes
    } core_data_req_t;

    // Request as seen by one memory port
    typedef struct packed {
        logic                      we;     // Write enable
        logic [BYTES_PER_WORD-1:0] mask;   // Byte lane write mask
        logic [WORD_ADDR_W-1:0]    addr;   // Word index
        logic [DATA_W-1:0]         wdata;  // Lane aligned write data
    } sram_req_t;

endpackage
